//--- common/oled_pkg.sv
// widths and control bit positions are fixed here and the bus write word is always 32 bits wide
`default_nettype none

package oled_pkg;

   localparam int unsigned BYTE_W  = 8;           // one spi payload byte
   localparam int unsigned ENTRY_W = BYTE_W + 1;  // payload plus dc tag in the msb
   localparam int unsigned WWORD_W = 32;          // system bus data width

   // control word bit positions
   localparam int unsigned CTRL_HOLD_BIT  = 0;    // keep cs_n low between frames
   localparam int unsigned CTRL_RST_BIT   = 1;    // level driven onto the panel reset pin
   localparam int unsigned CTRL_OVCLR_BIT = 2;    // write 1 to clear the sticky overflow flag

   // the same bus word is read as control bits on sel_cntl
   // and as byte lanes on sel_cmd / sel_dat (lane 0 is the payload)
   typedef union packed {
      logic [WWORD_W-1:0]                ctrl;   // control view, bits above 2 reserved
      logic [WWORD_W/BYTE_W-1:0][BYTE_W-1:0] lanes; // payload view, upper lanes ignored
   } oled_wword_t;

endpackage

`default_nettype wire

//--- verilog/oled_write_port.sv
// one select per strobe only; byte writes into a full fifo are lost and latch overflow
`default_nettype none
`timescale 1ns/1ps

module oled_write_port (
   input  wire logic                          clk,
   input  wire logic                          arst_n,
   input  wire logic                          wstrb,      // single-cycle write strobe
   input  wire logic                          sel_cntl,   // control word target
   input  wire logic                          sel_cmd,    // command byte target
   input  wire logic                          sel_dat,    // data byte target
   input  wire oled_pkg::oled_wword_t         wdata,
   input  wire logic                          full,       // fifo has no room this cycle
   output logic                               push,
   output logic [oled_pkg::ENTRY_W-1:0]       push_entry,
   output logic                               rst_n,      // panel reset, active low
   output logic                               cs_hold,    // manual chip-select hold
   output logic                               overflow    // sticky, a byte was dropped
);

   logic byte_wr;   // command or data byte write this cycle
   logic ctrl_wr;   // control word write this cycle

   assign byte_wr = wstrb & (sel_cmd | sel_dat);
   assign ctrl_wr = wstrb & sel_cntl;

   // fifo captures on the coming edge, full is current so no extra margin is needed
   assign push = byte_wr & ~full;

   // tag is 1 for data, 0 for command, byte comes from lane 0
   assign push_entry = {sel_dat, wdata.lanes[0]};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rst_n    <= 1'b0;   // panel held in reset until software says otherwise
         cs_hold  <= 1'b0;
         overflow <= 1'b0;
      end else if (ctrl_wr) begin
         rst_n   <= wdata.ctrl[oled_pkg::CTRL_RST_BIT];
         cs_hold <= wdata.ctrl[oled_pkg::CTRL_HOLD_BIT];
         if (wdata.ctrl[oled_pkg::CTRL_OVCLR_BIT]) begin
            overflow <= 1'b0;
         end
      end else if (byte_wr) begin
         rst_n <= 1'b1;       // any byte to the panel also releases reset
         if (full) begin
            overflow <= 1'b1; // byte lost
         end
      end
   end

   // decode only handles one target per strobe
   assert property (@(posedge clk) disable iff (!arst_n)
      wstrb |-> $onehot0({sel_cntl, sel_cmd, sel_dat}))
      else $error("oled_write_port: more than one select with wstrb");

endmodule

`default_nettype wire

//--- oled_fifo/oled_byte_fifo.sv
// show-ahead fifo, FIFO_AW must be 1 or more and the producer must not push while full
`default_nettype none
`timescale 1ns/1ps

module oled_byte_fifo #(
   parameter int unsigned FIFO_AW = 2              // log2 of the depth
) (
   input  wire logic                          clk,
   input  wire logic                          arst_n,
   input  wire logic                          push,
   input  wire logic [oled_pkg::ENTRY_W-1:0]  push_entry,
   input  wire logic                          pop,
   output logic [oled_pkg::ENTRY_W-1:0]       head,   // valid whenever empty is low
   output logic                               empty,
   output logic                               full
);

   localparam int unsigned DEPTH = 2 ** FIFO_AW;

   logic [oled_pkg::ENTRY_W-1:0] mem [DEPTH];  // entry storage
   logic [FIFO_AW:0]             wptr;         // extra msb tells wrap parity
   logic [FIFO_AW:0]             rptr;

   // read and write pointers
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wptr <= '0;
         rptr <= '0;
      end else begin
         if (push) begin
            wptr <= wptr + 1'b1;
         end
         if (pop) begin
            rptr <= rptr + 1'b1;   // independent of push, both may happen together
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wptr[FIFO_AW-1:0]] <= push_entry;
      end
   end

   assign head  = mem[rptr[FIFO_AW-1:0]];   // show-ahead read
   assign empty = (wptr == rptr);
   // same slot, different lap
   assign full  = (wptr[FIFO_AW] != rptr[FIFO_AW]) &&
                  (wptr[FIFO_AW-1:0] == rptr[FIFO_AW-1:0]);

   // write port is expected to check full before it pushes
   assert property (@(posedge clk) disable iff (!arst_n) !(push && full))
      else $error("oled_byte_fifo: push while full");

   // the shifter only takes the head when something is there
   assert property (@(posedge clk) disable iff (!arst_n) !(pop && empty))
      else $error("oled_byte_fifo: pop while empty");

endmodule

`default_nettype wire

//--- oled_spi/oled_spi_shifter.sv
// spi mode 0 style output, msb first, one serial period is 2**(SCLK_DIV_LOG2+1) clk cycles
`default_nettype none
`timescale 1ns/1ps

module oled_spi_shifter #(
   parameter int unsigned SCLK_DIV_LOG2 = 1   // log2 of the sclk half period in clk cycles
) (
   input  wire logic                          clk,
   input  wire logic                          arst_n,
   input  wire logic [oled_pkg::ENTRY_W-1:0]  head,     // {dc, byte} at the fifo head
   input  wire logic                          empty,
   input  wire logic                          cs_hold,  // keep cs_n low while idle
   output logic                               pop,      // one-cycle take of the head
   output logic                               active,   // frame bits still going out
   output logic                               din,
   output logic                               sclk,
   output logic                               cs_n,
   output logic                               dc
);

   localparam int unsigned DIV_W = SCLK_DIV_LOG2 + 1;

   logic [DIV_W-1:0]            div_q;    // free-running divider, msb is sclk
   logic                        tick;     // last clk of a serial period, sclk falls after it
   logic [3:0]                  bitcnt;   // bits left including the one on din, 0 is idle
   logic [oled_pkg::BYTE_W-1:0] shreg;    // msb drives din
   logic                        take;     // load the head at this tick

   assign tick = &div_q;
   assign sclk = div_q[DIV_W-1];
   assign din  = shreg[oled_pkg::BYTE_W-1];

   assign active = (bitcnt != 4'd0);
   // take when idle or when the eighth bit ends, so frames run back to back
   assign take   = tick && !empty && (bitcnt <= 4'd1);
   assign pop    = take;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         div_q <= '0;
      end else begin
         div_q <= div_q + 1'b1;   // wraps at the tick
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         bitcnt <= 4'd0;
         shreg  <= '0;       // din low out of reset
         cs_n   <= 1'b1;
         dc     <= 1'b0;
      end else if (tick) begin
         if (take) begin
            bitcnt <= 4'(oled_pkg::BYTE_W);
            shreg  <= head[oled_pkg::BYTE_W-1:0];
            dc     <= head[oled_pkg::ENTRY_W-1];   // tag sits above the byte
            cs_n   <= 1'b0;                        // frame opens with the first bit
         end else if (active) begin
            bitcnt <= bitcnt - 4'd1;
            shreg  <= {shreg[oled_pkg::BYTE_W-2:0], 1'b0};
            if (bitcnt == 4'd1) begin
               cs_n <= ~cs_hold;   // last bit done and nothing queued
            end
         end else begin
            // idle with nothing queued, follow the hold bit
            cs_n <= ~cs_hold;
         end
      end
   end

   // chip select must frame every bit being sent
   assert property (@(posedge clk) disable iff (!arst_n) active |-> !cs_n)
      else $error("oled_spi_shifter: bit on din without cs_n low");

   assert property (@(posedge clk) disable iff (!arst_n)
      bitcnt <= 4'(oled_pkg::BYTE_W))
      else $error("oled_spi_shifter: bit counter above byte width");

endmodule

`default_nettype wire

//--- verilog/oled_spi_top.sv
// busy and full are advisory, bytes written while full are dropped and control writes are not queued
`default_nettype none
`timescale 1ns/1ps

module oled_spi_top #(
   parameter int unsigned SCLK_DIV_LOG2 = 1,   // 1 gives sclk at clk/4
   parameter int unsigned FIFO_AW       = 2    // 4 queued bytes
) (
   input  wire logic        clk,
   input  wire logic        arst_n,
   input  wire logic        wstrb,
   input  wire logic        sel_cntl,
   input  wire logic        sel_cmd,
   input  wire logic        sel_dat,
   input  wire logic [31:0] wdata,
   output logic             busy,      // bytes queued or on the wire
   output logic             full,
   output logic             overflow,
   output logic             din,       // panel pins
   output logic             sclk,
   output logic             cs_n,
   output logic             dc,
   output logic             rst_n
);

   logic                         push;
   logic [oled_pkg::ENTRY_W-1:0] push_entry;
   logic                         pop;
   logic [oled_pkg::ENTRY_W-1:0] head;
   logic                         empty;
   logic                         active;
   logic                         cs_hold;

   assign busy = !empty || active;

   oled_write_port u_wport (
      .clk        (clk),
      .arst_n     (arst_n),
      .wstrb      (wstrb),
      .sel_cntl   (sel_cntl),
      .sel_cmd    (sel_cmd),
      .sel_dat    (sel_dat),
      .wdata      (wdata),       // raw bus word, decoded through the union inside
      .full       (full),
      .push       (push),
      .push_entry (push_entry),
      .rst_n      (rst_n),
      .cs_hold    (cs_hold),
      .overflow   (overflow)
   );

   oled_byte_fifo #(
      .FIFO_AW (FIFO_AW)
   ) u_fifo (
      .clk        (clk),
      .arst_n     (arst_n),
      .push       (push),
      .push_entry (push_entry),
      .pop        (pop),
      .head       (head),
      .empty      (empty),
      .full       (full)
   );

   oled_spi_shifter #(
      .SCLK_DIV_LOG2 (SCLK_DIV_LOG2)
   ) u_shift (
      .clk     (clk),
      .arst_n  (arst_n),
      .head    (head),
      .empty   (empty),
      .cs_hold (cs_hold),
      .pop     (pop),
      .active  (active),
      .din     (din),
      .sclk    (sclk),
      .cs_n    (cs_n),
      .dc      (dc)
   );

endmodule

`default_nettype wire

//--- testbench/tb_spi_capture.sv
// samples msb first on sclk rising edges while cs_n is low, enable low drops any partial byte
`default_nettype none
`timescale 1ns/1ps

module tb_spi_capture (
   input  wire logic  arst_n,
   input  wire logic  enable,       // low while cs_n idles low under the hold
   input  wire logic  sclk,
   input  wire logic  cs_n,
   input  wire logic  din,
   input  wire logic  dc,
   output logic [8:0] last_entry,   // {dc, byte} of the newest full byte
   output int unsigned byte_count,
   output int unsigned frame_count  // cs_n falling edges seen while enabled
);

   logic [6:0]  shift_in;   // first seven bits of the byte
   int unsigned nbits;   // bits gathered so far in this byte

   always @(posedge sclk or negedge arst_n) begin
      if (!arst_n) begin
         shift_in   <= '0;
         nbits      <= 0;
         last_entry <= '0;
         byte_count <= 0;
      end else if (cs_n || !enable) begin
         nbits <= 0;                   // frame closed, start over
      end else if (nbits == 7) begin
         last_entry <= {dc, shift_in, din};   // dc is steady over the byte
         byte_count <= byte_count + 1;
         nbits      <= 0;
      end else begin
         shift_in <= {shift_in[5:0], din};
         nbits    <= nbits + 1;
      end
   end

   // back to back bytes share one frame, so this counts frames and not bytes
   always @(negedge cs_n or negedge arst_n) begin
      if (!arst_n) begin
         frame_count <= 0;
      end else if (enable) begin
         frame_count <= frame_count + 1;
      end
   end

endmodule

`default_nettype wire

//--- testbench/tb_oled_spi.sv
// fixed to SCLK_DIV_LOG2 1 and FIFO_AW 2, the reference model counts serial ticks from reset release
`default_nettype none
`timescale 1ns/1ps

module tb_oled_spi;

   localparam int unsigned SCLK_DIV_LOG2 = 1;
   localparam int unsigned FIFO_AW       = 2;
   localparam int unsigned DEPTH         = 2 ** FIFO_AW;
   localparam int unsigned PERIOD        = 2 ** (SCLK_DIV_LOG2 + 1); // clk cycles per sclk
   localparam int unsigned MAX_ROWS      = 32;
   localparam int unsigned BUSY_LIMIT    = 400;   // five back to back bytes plus slack

   logic                  clk;
   logic                  arst_n;
   logic                  wstrb;
   logic                  sel_cntl;
   logic                  sel_cmd;
   logic                  sel_dat;
   oled_pkg::oled_wword_t wdata;
   logic                  busy;
   logic                  full;
   logic                  overflow;
   logic                  din;
   logic                  sclk;
   logic                  cs_n;
   logic                  dc;
   logic                  rst_n;

   logic       cap_en;       // capture listens only while this is high
   logic [8:0] cap_entry;
   int unsigned cap_bytes;
   int unsigned cap_frames;

   // model state, updated on rising clk and read on falling clk
   int unsigned                  div_m;
   int unsigned                  cnt_m;   // entries in the fifo
   int unsigned                  bits_m;  // bits left in the current frame
   logic                         csn_m;
   logic                         rst_m;
   logic                         hold_m;
   logic                         ovf_m;
   logic [oled_pkg::ENTRY_W-1:0] exp_q [$];   // accepted entries still to reach the pins

   int unsigned errors = 0;
   int unsigned checks = 0;
   int unsigned seen_bytes = 0;
   int unsigned frames_mark = 0;
   int unsigned nrows = 0;

   // stimulus table, sel 0 is control, 1 command, 2 data
   int unsigned           row_sel    [MAX_ROWS];
   oled_pkg::oled_wword_t row_word   [MAX_ROWS];
   int unsigned           row_idle   [MAX_ROWS];   // idle cycles before the strobe
   logic                  row_wait   [MAX_ROWS];   // wait for busy low afterwards
   int unsigned           row_frames [MAX_ROWS];   // cs_n frames since the last wait row

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   oled_spi_top #(
      .SCLK_DIV_LOG2 (SCLK_DIV_LOG2),
      .FIFO_AW       (FIFO_AW)
   ) dut0 (
      .clk      (clk),
      .arst_n   (arst_n),
      .wstrb    (wstrb),
      .sel_cntl (sel_cntl),
      .sel_cmd  (sel_cmd),
      .sel_dat  (sel_dat),
      .wdata    (wdata),
      .busy     (busy),
      .full     (full),
      .overflow (overflow),
      .din      (din),
      .sclk     (sclk),
      .cs_n     (cs_n),
      .dc       (dc),
      .rst_n    (rst_n)
   );

   tb_spi_capture cap0 (
      .arst_n      (arst_n),
      .enable      (cap_en),
      .sclk        (sclk),
      .cs_n        (cs_n),
      .din         (din),
      .dc          (dc),
      .last_entry  (cap_entry),
      .byte_count  (cap_bytes),
      .frame_count (cap_frames)
   );

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, exp, act);
      end
   endtask

   task automatic add_row(input int unsigned sel, input oled_pkg::oled_wword_t word,
                          input int unsigned idle, input logic wait_busy,
                          input int unsigned frames);
      row_sel[nrows]    = sel;
      row_word[nrows]   = word;   // byte rows carry random upper lanes
      row_idle[nrows]   = idle;
      row_wait[nrows]   = wait_busy;
      row_frames[nrows] = frames;
      nrows++;
   endtask

   task automatic wait_busy_low(input int unsigned limit);
      int unsigned n;
      n = 0;
      while (busy && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (busy) begin
         errors++;
         $display("timeout at %0t, busy still high after %0d cycles", $time, limit);
      end
   endtask

   task automatic wait_cs_high(input int unsigned limit);
      int unsigned n;
      n = 0;
      while (!cs_n && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (!cs_n) begin
         errors++;
         $display("timeout at %0t, cs_n did not rise after the hold was released", $time);
      end
   endtask

   task automatic apply_row(input int unsigned r);
      wdata    = row_word[r];
      sel_cntl = (row_sel[r] == 0);
      sel_cmd  = (row_sel[r] == 1);
      sel_dat  = (row_sel[r] == 2);
      wstrb    = 1'b1;
      @(negedge clk);
      wstrb    = 1'b0;
      sel_cntl = 1'b0;
      sel_cmd  = 1'b0;
      sel_dat  = 1'b0;
      if (row_sel[r] == 0 && !cap_en && !hold_m) begin
         wait_cs_high(4 * PERIOD);   // cs_n rises at the next tick
         cap_en = 1'b1;
      end
      if (row_wait[r]) begin
         wait_busy_low(BUSY_LIMIT);
         check_value("cs_n after busy", 32'(!hold_m), 32'(cs_n));
         check_value("frames", row_frames[r], cap_frames - frames_mark);
         frames_mark = cap_frames;
         if (hold_m) begin
            cap_en = 1'b0;   // sclk keeps running with cs_n low, nothing real to capture
         end
      end
   endtask

   // queue occupancy, serial ticks and frame state from the timing rules
   always @(posedge clk or negedge arst_n) begin
      logic tick;
      logic take;
      logic full_now;
      if (!arst_n) begin
         div_m  = 0;
         cnt_m  = 0;
         bits_m = 0;
         csn_m  = 1'b1;
         rst_m  = 1'b0;
         hold_m = 1'b0;
         ovf_m  = 1'b0;
      end else begin
         tick     = (div_m == PERIOD - 1);
         take     = tick && (cnt_m != 0) && (bits_m <= 1);   // idle or on the last bit
         full_now = (cnt_m == DEPTH);
         if (tick) begin
            if (take) begin
               bits_m = 8;
               csn_m  = 1'b0;
               cnt_m--;
            end else begin
               if (bits_m != 0) bits_m--;
               if (bits_m == 0) csn_m = !hold_m;   // hold level before this edge
            end
         end
         if (wstrb && sel_cntl) begin
            rst_m  = wdata.ctrl[oled_pkg::CTRL_RST_BIT];
            hold_m = wdata.ctrl[oled_pkg::CTRL_HOLD_BIT];
            if (wdata.ctrl[oled_pkg::CTRL_OVCLR_BIT]) ovf_m = 1'b0;
         end else if (wstrb && (sel_cmd || sel_dat)) begin
            rst_m = 1'b1;
            if (full_now) begin
               ovf_m = 1'b1;            // byte dropped
            end else begin
               exp_q.push_back({sel_dat, wdata.lanes[0]});
               cnt_m++;
            end
         end
         div_m = (div_m + 1) % PERIOD;
      end
   end

   // outputs against the model, every falling edge
   always @(negedge clk) begin
      if (arst_n) begin
         check_value("busy", 32'((cnt_m != 0) || (bits_m != 0)), 32'(busy));
         check_value("full", 32'(cnt_m == DEPTH), 32'(full));
         check_value("overflow", 32'(ovf_m), 32'(overflow));
         check_value("rst_n", 32'(rst_m), 32'(rst_n));
         check_value("cs_n", 32'(csn_m), 32'(cs_n));
         check_value("sclk", 32'(div_m >= PERIOD / 2), 32'(sclk));
         if (cap_bytes != seen_bytes) begin
            seen_bytes++;
            if (exp_q.size() == 0) begin
               errors++;
               $display("byte %0h captured at %0t with nothing expected", cap_entry, $time);
            end else begin
               check_value("spi entry", 32'(exp_q.pop_front()), 32'(cap_entry));
            end
         end
      end
   end

   initial begin
      void'($urandom(32'hf0de_833f));
      arst_n    = 1'b0;
      wstrb     = 1'b0;
      sel_cntl  = 1'b0;
      sel_cmd   = 1'b0;
      sel_dat   = 1'b0;
      wdata     = '0;
      cap_en    = 1'b1;
      add_row(1, $urandom, 2, 1'b1, 1);   // single bytes
      add_row(2, $urandom, 3, 1'b1, 1);
      add_row(1, $urandom, 1, 1'b1, 1);
      add_row(2, $urandom, 4, 1'b0, 0);   // burst of four, one frame
      add_row(1, $urandom, 0, 1'b0, 0);
      add_row(2, $urandom, 0, 1'b0, 0);
      add_row(2, $urandom, 0, 1'b1, 1);
      add_row(2, $urandom, 5, 1'b0, 0);   // burst of six overruns the fifo
      add_row(2, $urandom, 0, 1'b0, 0);
      add_row(1, $urandom, 0, 1'b0, 0);
      add_row(2, $urandom, 0, 1'b0, 0);
      add_row(2, $urandom, 0, 1'b0, 0);
      add_row(1, $urandom, 0, 1'b1, 1);
      add_row(0, 32'hffff_fff2, 2, 1'b0, 0);   // reserved bits set, overflow kept
      add_row(0, 32'h0000_0006, 2, 1'b0, 0);   // overflow clear
      add_row(2, $urandom, 3, 1'b0, 0);
      add_row(0, 32'h0000_0003, 0, 1'b1, 1);   // hold while the byte is queued
      add_row(0, 32'h0000_0000, 6, 1'b0, 0);   // hold off, panel reset low
      add_row(2, $urandom, 5, 1'b1, 1);        // releases reset
      add_row(1, $urandom, 2, 1'b1, 1);
      repeat (8) @(negedge clk);
      arst_n = 1'b1;
      check_value("cs_n at reset", 32'h1, 32'(cs_n));
      check_value("rst_n at reset", 32'h0, 32'(rst_n));
      check_value("busy at reset", 32'h0, 32'(busy));
      check_value("dc at reset", 32'h0, 32'(dc));
      check_value("din at reset", 32'h0, 32'(din));
      for (int unsigned r = 0; r < nrows; r++) begin
         repeat (row_idle[r]) @(negedge clk);
         apply_row(r);
      end
      wait_busy_low(BUSY_LIMIT);
      repeat (4) @(negedge clk);
      if (exp_q.size() != 0) begin
         errors++;
         $display("%0d accepted bytes never reached the capture model", exp_q.size());
      end
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
common/oled_pkg.sv
verilog/oled_write_port.sv
oled_fifo/oled_byte_fifo.sv
oled_spi/oled_spi_shifter.sv
verilog/oled_spi_top.sv
testbench/tb_spi_capture.sv
testbench/tb_oled_spi.sv

//--- Makefile
TOOL       = verilator
TOP        = tb_oled_spi
FILELIST   = sim.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
PASS_TEXT  = SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)
